// File: files.f
+incdir+hw
hw/mem_pkg.sv
hw/sram_1r1w.sv
hw/init_seq.sv
hw/bank_map_table.sv
hw/bank_array.sv
hw/mem_1r2w_top.sv
test/mem_checker.sv
test/tb_mem_1r2w.sv

// File: hw/bank_array.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module bank_array import mem_pkg::*; (
  input  logic   clk,
  input  logic   init_active,
  input  vrow_t  init_row,
  input  logic   wr0,
  input  vrow_t  wr0_vrow,
  input  data_t  wr0_din,
  input  pbank_t wr0_pbank,
  input  logic   wr1,
  input  vrow_t  wr1_vrow,
  input  data_t  wr1_din,
  input  pbank_t wr1_pbank,
  input  logic   rd,
  input  vrow_t  rd_vrow,
  input  pbank_t rd_pbank,
  output logic   rd_vld,
  output data_t  rd_dout
);

  data_t  bank_dout [`MEM_NUM_PBNK];
  pbank_t rd_pbank_q;

  for (genvar b = 0; b < `MEM_NUM_PBNK; b++) begin : g_bank
    logic  hit0;
    logic  hit1;
    logic  bank_wr;
    vrow_t bank_wr_adr;
    data_t bank_din;

    // the map table never steers both writes into one bank.
    assign hit0 = wr0 && (wr0_pbank == pbank_t'(b));
    assign hit1 = wr1 && (wr1_pbank == pbank_t'(b));

    assign bank_wr     = init_active || hit0 || hit1;
    assign bank_wr_adr = init_active ? init_row : (hit1 ? wr1_vrow : wr0_vrow);
    assign bank_din    = init_active ? '0 : (hit1 ? wr1_din : wr0_din);

    sram_1r1w u_sram (
      .clk    (clk),
      .write  (bank_wr),
      .wr_adr (bank_wr_adr),
      .din    (bank_din),
      .read   (rd),
      .rd_adr (rd_vrow),
      .dout   (bank_dout[b])
    );
  end

  always_ff @(posedge clk) begin
    rd_vld <= rd;
    if (rd) begin
      rd_pbank_q <= rd_pbank;
    end
  end

  // every bank was read and the registered mapping picks the one that holds the word.
  assign rd_dout = bank_dout[rd_pbank_q];

endmodule

// File: hw/bank_map_table.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module bank_map_table import mem_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   init_active,
  input  vbank_t rd_vbank,
  input  vrow_t  rd_vrow,
  input  logic   wr0,
  input  vbank_t wr0_vbank,
  input  vrow_t  wr0_vrow,
  input  logic   wr1,
  input  vbank_t wr1_vbank,
  input  vrow_t  wr1_vrow,
  output pbank_t rd_pbank,
  output pbank_t wr0_pbank,
  output pbank_t wr1_pbank
);

  // the physical bank that holds each virtual bank of a row.
  pbank_t map_q  [`MEM_NUM_VROW][`MEM_NUM_VBNK];
  // the one physical bank of a row that no virtual bank uses.
  pbank_t free_q [`MEM_NUM_VROW];

  pbank_t wr1_map;
  pbank_t wr1_free;
  logic   wr1_redirect;

  // all lookups see the map as it stood before this edge.
  assign rd_pbank  = map_q[rd_vrow][rd_vbank];
  assign wr0_pbank = map_q[wr0_vrow][wr0_vbank];
  assign wr1_map   = map_q[wr1_vrow][wr1_vbank];
  assign wr1_free  = free_q[wr1_vrow];

  // each bank has a single write port, so wr1 moves aside when both land on one bank.
  assign wr1_redirect = wr0 && wr1 && (wr0_pbank == wr1_map);

  assign wr1_pbank = wr1_redirect ? wr1_free : wr1_map;

  always_ff @(posedge clk) begin
    if (!rst_n || init_active) begin
      for (int r = 0; r < `MEM_NUM_VROW; r++) begin
        for (int v = 0; v < `MEM_NUM_VBNK; v++) begin
          map_q[r][v] <= pbank_t'(v);  // identity map.
        end
        free_q[r] <= pbank_t'(`MEM_NUM_VBNK);
      end
    end else if (wr1_redirect) begin
      // the word now lives in the old free bank, and its old slot is released.
      map_q[wr1_vrow][wr1_vbank] <= wr1_free;
      free_q[wr1_vrow]           <= wr1_map;
    end
  end

endmodule

// File: hw/init_seq.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module init_seq import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output logic  ready,
  output logic  init_active,
  output vrow_t init_row
);

  localparam vrow_t LAST_ROW = vrow_t'(`MEM_NUM_VROW - 1);

  init_state_t state_q;
  vrow_t       row_q;

  // one row of every bank is cleared per cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= INIT_CLEAR;
      row_q   <= '0;
    end else begin
      case (state_q)
        INIT_CLEAR: begin
          row_q <= row_q + 1'b1;
          if (row_q == LAST_ROW) begin
            state_q <= INIT_DONE;  // the last row is written at this edge.
          end
        end
        default: state_q <= INIT_DONE;
      endcase
    end
  end

  assign init_active = (state_q == INIT_CLEAR);
  assign ready       = (state_q == INIT_DONE);
  assign init_row    = row_q;

endmodule

// File: hw/mem_1r2w_top.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module mem_1r2w_top import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr0,
  input  addr_t wr0_adr,
  input  data_t wr0_din,
  input  logic  wr1,
  input  addr_t wr1_adr,
  input  data_t wr1_din,
  input  logic  rd,
  input  addr_t rd_adr,
  output logic  ready,
  output logic  rd_vld,
  output data_t rd_dout
);

  logic   init_active;
  vrow_t  init_row;
  logic   wr0_live;
  logic   wr1_live;
  logic   rd_live;
  vbank_t wr0_vbank;
  vbank_t wr1_vbank;
  vbank_t rd_vbank;
  vrow_t  wr0_vrow;
  vrow_t  wr1_vrow;
  vrow_t  rd_vrow;
  pbank_t wr0_pbank;
  pbank_t wr1_pbank;
  pbank_t rd_pbank;

  // requests before init completes are dropped.
  assign wr0_live = wr0 && ready;
  assign wr1_live = wr1 && ready;
  assign rd_live  = rd && ready;

  assign {wr0_vbank, wr0_vrow} = wr0_adr;
  assign {wr1_vbank, wr1_vrow} = wr1_adr;
  assign {rd_vbank, rd_vrow}   = rd_adr;

  init_seq u_init_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready       (ready),
    .init_active (init_active),
    .init_row    (init_row)
  );

  bank_map_table u_bank_map_table (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_active (init_active),
    .rd_vbank    (rd_vbank),
    .rd_vrow     (rd_vrow),
    .wr0         (wr0_live),
    .wr0_vbank   (wr0_vbank),
    .wr0_vrow    (wr0_vrow),
    .wr1         (wr1_live),
    .wr1_vbank   (wr1_vbank),
    .wr1_vrow    (wr1_vrow),
    .rd_pbank    (rd_pbank),
    .wr0_pbank   (wr0_pbank),
    .wr1_pbank   (wr1_pbank)
  );

  bank_array u_bank_array (
    .clk         (clk),
    .init_active (init_active),
    .init_row    (init_row),
    .wr0         (wr0_live),
    .wr0_vrow    (wr0_vrow),
    .wr0_din     (wr0_din),
    .wr0_pbank   (wr0_pbank),
    .wr1         (wr1_live),
    .wr1_vrow    (wr1_vrow),
    .wr1_din     (wr1_din),
    .wr1_pbank   (wr1_pbank),
    .rd          (rd_live),
    .rd_vrow     (rd_vrow),
    .rd_pbank    (rd_pbank),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout)
  );

endmodule

// File: hw/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define MEM_DATA_W    32
`define MEM_NUM_VBNK  4
`define MEM_BIT_VBNK  2
// one spare physical bank on top of the virtual ones.
`define MEM_NUM_PBNK  5
`define MEM_BIT_PBNK  3
`define MEM_NUM_VROW  16
`define MEM_BIT_VROW  4
`define MEM_BIT_ADDR  6  // virtual bank bits above the row bits.

`endif

// File: hw/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

  typedef logic [`MEM_DATA_W-1:0]   data_t;
  typedef logic [`MEM_BIT_ADDR-1:0] addr_t;   // {vbank, vrow}.
  typedef logic [`MEM_BIT_VBNK-1:0] vbank_t;
  typedef logic [`MEM_BIT_VROW-1:0] vrow_t;
  typedef logic [`MEM_BIT_PBNK-1:0] pbank_t;

  typedef enum logic {
    INIT_CLEAR,
    INIT_DONE
  } init_state_t;

endpackage

// File: hw/sram_1r1w.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module sram_1r1w import mem_pkg::*; (
  input  logic  clk,
  input  logic  write,
  input  vrow_t wr_adr,
  input  data_t din,
  input  logic  read,
  input  vrow_t rd_adr,
  output data_t dout
);

  data_t mem [`MEM_NUM_VROW];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_adr] <= din;
    end
  end

  // a read of the row being written this cycle sees the old word.
  always_ff @(posedge clk) begin
    if (read) begin
      dout <= mem[rd_adr];
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_mem_1r2w -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

// File: test/mem_checker.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module mem_checker import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr0,
  input  addr_t wr0_adr,
  input  data_t wr0_din,
  input  logic  wr1,
  input  addr_t wr1_adr,
  input  data_t wr1_din,
  input  logic  rd,
  input  addr_t rd_adr,
  input  logic  ready,
  input  logic  rd_vld,
  input  data_t rd_dout,
  input  logic  tbl_chk,
  input  data_t tbl_exp,
  output int    mismatch_cnt,
  output int    protocol_cnt,
  output logic  pending
);

  localparam int NUM_ADDR = 1 << `MEM_BIT_ADDR;

  data_t shadow [NUM_ADDR];  // reference copy of every address.
  data_t exp_dout;
  data_t exp_tbl;
  logic  exp_tbl_chk;
  logic  ready_seen;
  logic  started = 1'b0;
  int    rel_edges;  // rising edges since rst_n was released.

  task automatic report_mismatch(string name, data_t expected, data_t actual);
    mismatch_cnt++;
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  // the expected word is taken before this edge's writes land, and wr1 lands after wr0.
  always @(posedge clk) begin
    started <= 1'b1;
    if (!rst_n) begin
      rel_edges <= 0;
      pending   <= 1'b0;
      for (int i = 0; i < NUM_ADDR; i++) begin
        shadow[i] <= '0;
      end
    end else begin
      rel_edges   <= rel_edges + 1;
      pending     <= rd && ready_seen;
      exp_dout    <= shadow[rd_adr];
      exp_tbl     <= tbl_exp;
      exp_tbl_chk <= tbl_chk;
      if (wr0 && ready_seen) begin
        shadow[wr0_adr] <= wr0_din;
      end
      if (wr1 && ready_seen) begin
        shadow[wr1_adr] <= wr1_din;
      end
    end
  end

  // outputs only move after a rising edge, so they are compared on the falling one.
  always @(negedge clk) begin
    logic exp_ready;
    exp_ready  = (rel_edges >= `MEM_NUM_VROW);
    ready_seen <= exp_ready;  // the ready level the DUT must show at the next rising edge.
    if (started) begin
      if (ready !== exp_ready) begin
        report_mismatch("ready", data_t'(exp_ready), data_t'(ready));
      end
      if (pending && rd_vld !== 1'b1) begin
        protocol_cnt++;
        $display("%0t: a read was accepted but rd_vld did not follow one cycle later", $time);
      end else if (!pending && rd_vld !== 1'b0) begin
        protocol_cnt++;
        $display("%0t: rd_vld was high with no read accepted on the edge before", $time);
      end else if (pending) begin
        if (rd_dout !== exp_dout) begin
          report_mismatch("rd_dout", exp_dout, rd_dout);
        end
        if (exp_tbl_chk && rd_dout !== exp_tbl) begin
          report_mismatch("rd_dout against table", exp_tbl, rd_dout);  // hand-computed value.
        end
      end
    end
  end

endmodule

// File: test/tb_mem_1r2w.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module tb_mem_1r2w import mem_pkg::*; ();

  localparam int READY_LIMIT = 40;
  localparam int DRAIN_LIMIT = 8;
  localparam int RAND_STEPS  = 200;

  typedef struct packed {
    logic  wr0;
    addr_t wr0_adr;
    data_t wr0_din;
    logic  wr1;
    addr_t wr1_adr;
    data_t wr1_din;
    logic  rd;
    addr_t rd_adr;
    logic  chk;  // exp holds a hand-derived read value.
    data_t exp;
  } step_t;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  wr0;
  addr_t wr0_adr;
  data_t wr0_din;
  logic  wr1;
  addr_t wr1_adr;
  data_t wr1_din;
  logic  rd;
  addr_t rd_adr;
  logic  ready;
  logic  rd_vld;
  data_t rd_dout;
  logic  tbl_chk;
  data_t tbl_exp;
  int    mismatch_cnt;
  int    protocol_cnt;
  logic  pending;
  int    timeout_cnt;
  step_t steps [$];
  data_t rnd [13];

  always #20 clk = ~clk;

  mem_1r2w_top u_mem_1r2w_top (.*);

  mem_checker u_mem_checker (.*);

  function automatic void add_step(logic w0, addr_t a0, data_t d0, logic w1, addr_t a1,
                                   data_t d1, logic r, addr_t ra, logic chk, data_t exp);
    steps.push_back('{w0, a0, d0, w1, a1, d1, r, ra, chk, exp});
  endfunction

  // a few rows only, so random writes collide and reads hit written words often.
  function automatic addr_t pick_addr();
    return {vbank_t'($urandom), vrow_t'($urandom % 4)};
  endfunction

  function automatic void build_steps();
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h00, 1, '0);  // all zero after init.
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h15, 1, '0);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h2a, 1, '0);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h3f, 1, '0);
    add_step(1, 6'h03, rnd[0], 0, 6'h00, '0, 0, 6'h00, 0, '0);
    add_step(0, 6'h00, '0, 1, 6'h13, rnd[1], 1, 6'h03, 1, rnd[0]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h13, 1, rnd[1]);
    // wr1 keeps landing in row 2 while wr0 hits the same physical bank elsewhere.
    add_step(1, 6'h01, rnd[2], 1, 6'h02, rnd[3], 0, 6'h00, 0, '0);
    add_step(1, 6'h16, rnd[4], 1, 6'h12, rnd[5], 1, 6'h01, 1, rnd[2]);
    add_step(1, 6'h26, rnd[6], 1, 6'h22, rnd[7], 1, 6'h02, 1, rnd[3]);
    add_step(1, 6'h36, rnd[8], 1, 6'h32, rnd[9], 1, 6'h12, 1, rnd[5]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h22, 1, rnd[7]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h32, 1, rnd[9]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h16, 1, rnd[4]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h26, 1, rnd[6]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h36, 1, rnd[8]);
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h02, 1, rnd[3]);
    add_step(1, 6'h2c, rnd[10], 1, 6'h2c, rnd[11], 0, 6'h00, 0, '0);  // wr1 wins.
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h2c, 1, rnd[11]);
    add_step(1, 6'h03, rnd[12], 0, 6'h00, '0, 1, 6'h03, 1, rnd[0]);  // old word.
    add_step(0, 6'h00, '0, 0, 6'h00, '0, 1, 6'h03, 1, rnd[12]);
    for (int i = 0; i < RAND_STEPS; i++) begin
      add_step(1'($urandom), pick_addr(), $urandom, 1'($urandom), pick_addr(), $urandom,
               1'b1, pick_addr(), 1'b0, '0);
    end
  endfunction

  task automatic apply_step(step_t s);
    wr0     = s.wr0;
    wr0_adr = s.wr0_adr;
    wr0_din = s.wr0_din;
    wr1     = s.wr1;
    wr1_adr = s.wr1_adr;
    wr1_din = s.wr1_din;
    rd      = s.rd;
    rd_adr  = s.rd_adr;
    tbl_chk = s.chk;
    tbl_exp = s.exp;
  endtask

  task automatic run_steps();
    foreach (steps[i]) begin
      apply_step(steps[i]);
      @(negedge clk);
    end
    apply_step('0);
  endtask

  initial begin
    int ready_wait;
    int drain_wait;
    int failures;
    $timeformat(-9, 0, " ns", 0);
    apply_step('0);
    rst_n       = 1'b0;
    timeout_cnt = 0;
    void'($urandom(32'h30de));
    foreach (rnd[i]) begin
      rnd[i] = $urandom;
    end
    build_steps();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    rd    = 1'b1;  // must be ignored until ready.
    ready_wait = 0;
    while (ready !== 1'b1 && ready_wait < READY_LIMIT) begin
      @(negedge clk);
      ready_wait++;
    end
    if (ready !== 1'b1) begin
      $display("ready did not rise within %0d cycles after reset", READY_LIMIT);
      $display("Simulation failed");
      $finish;
    end else begin
      run_steps();
      drain_wait = 0;
      while (pending === 1'b1 && drain_wait < DRAIN_LIMIT) begin
        @(negedge clk);
        drain_wait++;
      end
      if (pending === 1'b1) begin
        timeout_cnt++;
        $display("the last read never completed within %0d cycles", DRAIN_LIMIT);
      end
      @(posedge clk);
      failures = mismatch_cnt + protocol_cnt + timeout_cnt;
      $display("errors: %0d mismatches, %0d handshake errors, %0d timeouts",
               mismatch_cnt, protocol_cnt, timeout_cnt);
      if (failures == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule
